/* common/glb_cfg_pkg.sv */
// Global buffer configuration types.
// Address fields, data words, tile ids and the bank read state.

package glb_cfg_pkg;

    import glb_param_pkg::*;

    // Full address: tile select, bank select, bank word address.
    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;

    typedef logic [BANK_SEL_ADDR_WIDTH-1:0] bank_sel_t;

    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;

    // Read pipeline state of one configuration bank.
    typedef enum logic [1:0] {
        rd_idle   = 2'd0, // no read in flight.
        rd_access = 2'd1, // word captured, output not yet updated.
        rd_return = 2'd2  // last word on the output, nothing new captured.
    } bank_rd_state_t;

endpackage

/* common/glb_param_pkg.sv */
// Global buffer configuration parameters.
// Sizes of the tile chain, the banks and the configuration address fields.

package glb_param_pkg;

    // tile chain
    localparam int NUM_TILES = 4;
    localparam int TILE_SEL_ADDR_WIDTH = 3; // ids 4 to 7 select no tile.

    // banks inside a tile
    localparam int BANKS_PER_TILE = 2;
    localparam int BANK_SEL_ADDR_WIDTH = 1;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH; // 64 words per bank.

    // full configuration address, tile select on top
    localparam int CFG_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH
                                  + BANK_SEL_ADDR_WIDTH
                                  + BANK_ADDR_WIDTH;

    // field positions inside the address
    localparam int BANK_SEL_LSB = BANK_ADDR_WIDTH;
    localparam int TILE_SEL_LSB = BANK_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH;

    // configuration word
    localparam int CFG_DATA_WIDTH = 32;

    // Cycles from a bank read strobe to its valid data.
    localparam int BANK_RD_LATENCY = 2;

endpackage

/* dv/glb_cfg_assert.sv */
// Timing checks on the configuration chain.
// Books every read of a real tile for cycle 2t+3 and compares the top valid with it.

`timescale 1ns/1ps

module glb_cfg_assert
    import glb_param_pkg::*, glb_cfg_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      wr_en,
    input logic      rd_en,
    input cfg_addr_t rd_addr,
    input cfg_data_t rd_data,
    input logic      rd_data_valid
);

    tile_id_t             rd_tile;
    logic [2*NUM_TILES:0] due;      // bit 0 marks the edge where valid is expected.
    logic [2*NUM_TILES:0] due_next;
    int unsigned          fail_count = 0;

    assign rd_tile = rd_addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH];

    // A read of tile t is due 2t+3 edges after the edge that samples it.
    always_comb begin
        due_next = due >> 1;
        if (rd_en && (int'(rd_tile) < NUM_TILES)) begin
            due_next[2*rd_tile+2] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            due <= '0;
        end else begin
            due <= due_next;
        end
    end

    valid_on_schedule: assert property (@(posedge clk) disable iff (reset)
        rd_data_valid == due[0])
        else begin
            fail_count++;
            $error("top read valid does not follow the 2t+3 read schedule");
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!rd_data_valid && (rd_data == '0)))
        else begin
            fail_count++;
            $error("read return is not cleared while reset is high");
        end

    known_strobes: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({wr_en, rd_en, rd_data_valid}))
        else begin
            fail_count++;
            $error("a request or valid strobe is unknown");
        end

    known_read_data: assert property (@(posedge clk) disable iff (reset)
        rd_data_valid |-> !$isunknown(rd_data))
        else begin
            fail_count++;
            $error("returned read data holds unknown bits");
        end

endmodule

bind glb_cfg_top glb_cfg_assert glb_cfg_assert_inst (
    .clk           (clk),
    .reset         (reset),
    .wr_en         (wr_en),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
);

/* dv/glb_cfg_tb.sv */
// Testbench for the global buffer configuration chain.
// Writes and reads configuration words through the tiles against a memory model.

`timescale 1ns/1ps

module glb_cfg_tb
    import glb_param_pkg::*, glb_cfg_pkg::*;
();

    localparam int RESP_TIMEOUT  = 20;
    localparam int TILE_SPAN     = 1 << TILE_SEL_LSB;   // words behind one tile select.
    localparam int VALID_SPAN    = NUM_TILES * TILE_SPAN;
    localparam int UNMAPPED_SELS = (1 << TILE_SEL_ADDR_WIDTH) - NUM_TILES;
    localparam int RANDOM_OPS    = 200;

    logic      clk;
    logic      reset;
    logic      wr_en;
    cfg_addr_t wr_addr;
    cfg_data_t wr_data;
    logic      rd_en;
    cfg_addr_t rd_addr;
    cfg_data_t rd_data;
    logic      rd_data_valid;

    cfg_data_t   ref_mem [1 << CFG_ADDR_WIDTH];
    logic [31:0] rng_state = 32'h1de3c964;
    int unsigned cyc = 0;
    int unsigned error_count = 0;
    int unsigned check_count = 0;
    int unsigned test_count = 0;
    int unsigned test_start_errors = 0;
    int          exp_cycle [$]; // return cycles of booked reads, earliest first.
    cfg_data_t   exp_data [$];

    glb_clk_gen glb_clk_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    glb_cfg_top glb_cfg_top_inst (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    always @(posedge clk) cyc <= cyc + 1; // index of the cycle now running.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    function automatic int tile_of(input cfg_addr_t addr);
        return int'(addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH]);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // One cycle of request strobes. A read of tile t returns in cycle 2t+3.
    task automatic issue(input logic do_wr, input cfg_addr_t waddr, input cfg_data_t wdata,
                         input logic do_rd, input cfg_addr_t raddr);
        int due;
        int pos;
        wr_en   = do_wr;
        wr_addr = waddr;
        wr_data = wdata;
        rd_en   = do_rd;
        rd_addr = raddr;
        if (do_rd && tile_of(raddr) < NUM_TILES) begin
            due = cyc + 2 * tile_of(raddr) + 3;
            pos = 0;
            while (pos < exp_cycle.size() && exp_cycle[pos] < due) pos++;
            exp_cycle.insert(pos, due);
            exp_data.insert(pos, ref_mem[raddr]); // taken before a write in the same cycle.
        end
        if (do_wr && tile_of(waddr) < NUM_TILES) begin
            ref_mem[waddr] = wdata;
        end
        next_cycle();
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic collect();
        int idle;
        idle = 0;
        while (exp_cycle.size() > 0 && idle < RESP_TIMEOUT) begin
            if (rd_data_valid === 1'b1) begin
                check_value("rd_data_valid cycle", exp_cycle[0], cyc);
                check_value("rd_data", exp_data[0], rd_data);
                void'(exp_cycle.pop_front());
                void'(exp_data.pop_front());
                idle = 0;
            end else begin
                idle++;
            end
            next_cycle();
        end
        if (exp_cycle.size() > 0) begin
            $display("no read response came back within %0d cycles, %0d reads lost",
                     RESP_TIMEOUT, exp_cycle.size());
            error_count++;
            exp_cycle.delete();
            exp_data.delete();
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            check_value("rd_data_valid", '0, rd_data_valid);
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        errs = error_count - test_start_errors;
        test_count++;
        $display("test %0d %-26s %s, %0d errors", test_count, name,
                 (errs == 0) ? "passed" : "FAILED", errs);
        test_start_errors = error_count;
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        cfg_addr_t   addr;
        int          waited;
        int          op;
        int unsigned assert_fails;
        int unsigned low [UNMAPPED_SELS];
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;

        waited = 0;
        while (reset !== 1'b0 && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            error_count++;
        end

        for (int n = 0; n < 5; n++) begin
            check_value("rd_data_valid", '0, rd_data_valid);
            check_value("rd_data", '0, rd_data);
            next_cycle();
        end
        finish_test("idle after reset");

        for (int a = 0; a < VALID_SPAN; a++) begin
            draw(r1);
            issue(1'b1, cfg_addr_t'(a), r1, 1'b0, '0);
        end
        for (int a = 0; a < VALID_SPAN; a++) begin
            issue(1'b0, '0, '0, 1'b1, cfg_addr_t'(a));
            collect();
        end
        finish_test("fill and read back");

        // Reads to tiles 3 down to 0 come back in reverse order, one per cycle.
        for (int round = 0; round < 4; round++) begin
            for (int t = NUM_TILES - 1; t >= 0; t--) begin
                draw(r1);
                addr = cfg_addr_t'(t * TILE_SPAN + (r1 % TILE_SPAN));
                issue(1'b0, '0, '0, 1'b1, addr);
            end
            collect();
        end
        finish_test("reads in flight");

        for (int t = 0; t < NUM_TILES; t++) begin
            draw(r1);
            draw(r2);
            addr = cfg_addr_t'(t * TILE_SPAN + (r1 % TILE_SPAN));
            issue(1'b1, addr, r2, 1'b1, addr);
            collect();
            issue(1'b0, '0, '0, 1'b1, addr);
            collect();
        end
        finish_test("write and read together");

        for (int s = NUM_TILES; s < (1 << TILE_SEL_ADDR_WIDTH); s++) begin
            draw(r1);
            draw(r2);
            low[s - NUM_TILES] = r1 % TILE_SPAN; // bank select and word below the tile select.
            addr = cfg_addr_t'(s * TILE_SPAN + low[s - NUM_TILES]);
            issue(1'b1, addr, r2, 1'b1, addr);
            expect_quiet(RESP_TIMEOUT);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int s = 0; s < UNMAPPED_SELS; s++) begin
                addr = cfg_addr_t'(t * TILE_SPAN + low[s]);
                issue(1'b0, '0, '0, 1'b1, addr);
                collect();
            end
        end
        finish_test("unmapped tile select");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            draw(r1);
            draw(r2);
            draw(r3);
            op = r1 % 3; // write, read, or both at once.
            issue(op != 1, cfg_addr_t'(r2 % VALID_SPAN), xorshift32(r1),
                  op != 0, cfg_addr_t'(r3 % VALID_SPAN));
            if (op != 0) begin
                collect();
            end
        end
        finish_test("random mix");

        expect_quiet(RESP_TIMEOUT);
        assert_fails = glb_cfg_top_inst.glb_cfg_assert_inst.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dv/glb_clk_gen.sv */
// Clock and reset source for the configuration testbench.
// 10 ns clock, reset held over the first ten rising edges.

`timescale 1ns/1ps

module glb_clk_gen (
    output logic clk,
    output logic reset
);

    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // released half a cycle away from any sampling edge.
    end

endmodule

/* files.f */
common/glb_param_pkg.sv
common/glb_cfg_pkg.sv
glb_tile/glb_cfg_bank.sv
glb_tile/glb_tile_cfg_ctrl.sv
glb_tile/glb_tile.sv
source/glb_cfg_top.sv
dv/glb_clk_gen.sv
dv/glb_cfg_assert.sv
dv/glb_cfg_tb.sv

/* glb_tile/glb_cfg_bank.sv */
// Configuration SRAM bank.
// A register array with a two-cycle registered read.

`timescale 1ns/1ps

module glb_cfg_bank
    import glb_param_pkg::*, glb_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  bank_addr_t wr_addr,
    input  cfg_data_t  wr_data,
    input  logic       rd_en,
    input  bank_addr_t rd_addr,
    output cfg_data_t  rd_data,
    output logic       rd_data_valid
);

    cfg_data_t mem [BANK_DEPTH];
    cfg_data_t rd_buf; // word taken at the read strobe.

    bank_rd_state_t rd_state;
    bank_rd_state_t rd_state_next;

    // The read word is captured on the strobe edge itself.
    // A write to the same word in that cycle lands after it, so the read sees old data.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_buf <= mem[rd_addr];
        end
    end

    // A new strobe always restarts rd_access, so reads on back-to-back cycles
    // simply keep the pipeline in that state.
    always_comb begin
        rd_state_next = rd_state;
        unique case (rd_state)
            rd_idle: begin
                if (rd_en) rd_state_next = rd_access;
            end
            rd_access: begin
                rd_state_next = rd_en ? rd_access : rd_return;
            end
            rd_return: begin
                rd_state_next = rd_en ? rd_access : rd_idle;
            end
            default: begin
                rd_state_next = rd_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_state      <= rd_idle;
            rd_data       <= '0;
            rd_data_valid <= 1'b0;
        end else begin
            rd_state      <= rd_state_next;
            rd_data_valid <= (rd_state == rd_access); // high while in rd_return or a repeat.
            if (rd_state == rd_access) begin
                rd_data <= rd_buf;
            end
        end
    end

endmodule

/* glb_tile/glb_tile.sv */
// One global buffer tile on the configuration chain.
// A configuration router in front of its configuration banks.

`timescale 1ns/1ps

module glb_tile
    import glb_param_pkg::*, glb_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  tile_id_t  tile_id,

    // west side
    input  logic      wr_en,
    input  cfg_addr_t wr_addr,
    input  cfg_data_t wr_data,
    input  logic      rd_en,
    input  cfg_addr_t rd_addr,
    output cfg_data_t rd_data,
    output logic      rd_data_valid,

    // east side
    output logic      est_wr_en,
    output cfg_addr_t est_wr_addr,
    output cfg_data_t est_wr_data,
    output logic      est_rd_en,
    output cfg_addr_t est_rd_addr,
    input  cfg_data_t est_rd_data,
    input  logic      est_rd_data_valid
);

    // Strobes are per bank, address and write data are shared.
    logic       bank_wr_en [BANKS_PER_TILE];
    bank_addr_t bank_wr_addr;
    cfg_data_t  bank_wr_data;
    logic       bank_rd_en [BANKS_PER_TILE];
    bank_addr_t bank_rd_addr;

    // return side of every bank, gathered for the router
    cfg_data_t  bank_rd_data [BANKS_PER_TILE];
    logic       bank_rd_data_valid [BANKS_PER_TILE];

    glb_tile_cfg_ctrl glb_tile_cfg_ctrl_inst (
        .clk                (clk),
        .reset              (reset),
        .tile_id            (tile_id),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .est_wr_en          (est_wr_en),
        .est_wr_addr        (est_wr_addr),
        .est_wr_data        (est_wr_data),
        .est_rd_en          (est_rd_en),
        .est_rd_addr        (est_rd_addr),
        .est_rd_data        (est_rd_data),
        .est_rd_data_valid  (est_rd_data_valid),
        .bank_wr_en         (bank_wr_en),
        .bank_wr_addr       (bank_wr_addr),
        .bank_wr_data       (bank_wr_data),
        .bank_rd_en         (bank_rd_en),
        .bank_rd_addr       (bank_rd_addr),
        .bank_rd_data       (bank_rd_data),
        .bank_rd_data_valid (bank_rd_data_valid)
    );

    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank
        glb_cfg_bank glb_cfg_bank_inst (
            .clk           (clk),
            .reset         (reset),
            .wr_en         (bank_wr_en[i]),
            .wr_addr       (bank_wr_addr),
            .wr_data       (bank_wr_data),
            .rd_en         (bank_rd_en[i]),
            .rd_addr       (bank_rd_addr),
            .rd_data       (bank_rd_data[i]),
            .rd_data_valid (bank_rd_data_valid[i])
        );
    end

endmodule

/* glb_tile/glb_tile_cfg_ctrl.sv */
// Per-tile configuration router.
// Passes requests east, strobes the local banks and merges read data going west.

`timescale 1ns/1ps

module glb_tile_cfg_ctrl
    import glb_param_pkg::*, glb_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  tile_id_t   tile_id,

    // west side
    input  logic       wr_en,
    input  cfg_addr_t  wr_addr,
    input  cfg_data_t  wr_data,
    input  logic       rd_en,
    input  cfg_addr_t  rd_addr,
    output cfg_data_t  rd_data,
    output logic       rd_data_valid,

    // east side
    output logic       est_wr_en,
    output cfg_addr_t  est_wr_addr,
    output cfg_data_t  est_wr_data,
    output logic       est_rd_en,
    output cfg_addr_t  est_rd_addr,
    input  cfg_data_t  est_rd_data,
    input  logic       est_rd_data_valid,

    // local banks
    output logic       bank_wr_en [BANKS_PER_TILE],
    output bank_addr_t bank_wr_addr,
    output cfg_data_t  bank_wr_data,
    output logic       bank_rd_en [BANKS_PER_TILE],
    output bank_addr_t bank_rd_addr,
    input  cfg_data_t  bank_rd_data [BANKS_PER_TILE],
    input  logic       bank_rd_data_valid [BANKS_PER_TILE]
);

    tile_id_t  wr_tile_sel;
    tile_id_t  rd_tile_sel;
    bank_sel_t wr_bank_sel;
    bank_sel_t rd_bank_sel;

    // Bit 0 is the strobe of one cycle ago, the top bit lines up with bank valid.
    logic [BANK_RD_LATENCY-1:0] rd_en_pipe [BANKS_PER_TILE];

    cfg_data_t rd_data_next;
    logic      rd_data_valid_next;

    assign wr_tile_sel = wr_addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH];
    assign wr_bank_sel = wr_addr[BANK_SEL_LSB +: BANK_SEL_ADDR_WIDTH];
    assign rd_tile_sel = rd_addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH];
    assign rd_bank_sel = rd_addr[BANK_SEL_LSB +: BANK_SEL_ADDR_WIDTH];

    // Address and data are shared by the banks, only the strobes are decoded.
    assign bank_wr_addr = wr_addr[BANK_ADDR_WIDTH-1:0];
    assign bank_wr_data = wr_data;
    assign bank_rd_addr = rd_addr[BANK_ADDR_WIDTH-1:0];

    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank_sel
        assign bank_wr_en[i] = wr_en && (wr_tile_sel == tile_id)
                               && (wr_bank_sel == bank_sel_t'(i));
        assign bank_rd_en[i] = rd_en && (rd_tile_sel == tile_id)
                               && (rd_bank_sel == bank_sel_t'(i));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < BANKS_PER_TILE; i++) begin
                rd_en_pipe[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BANKS_PER_TILE; i++) begin
                rd_en_pipe[i] <= (rd_en_pipe[i] << 1) | BANK_RD_LATENCY'(bank_rd_en[i]);
            end
        end
    end

    // Local data wins only in the cycle its own read completes.
    // The master spaces its reads so that a local return never meets data from the east.
    always_comb begin
        rd_data_next       = est_rd_data;
        rd_data_valid_next = est_rd_data_valid;
        for (int i = 0; i < BANKS_PER_TILE; i++) begin
            if (rd_en_pipe[i][BANK_RD_LATENCY-1]) begin
                rd_data_next       = bank_rd_data[i];
                rd_data_valid_next = bank_rd_data_valid[i];
            end
        end
    end

    // one register stage per tile in both directions
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr_en     <= 1'b0;
            est_wr_addr   <= '0;
            est_wr_data   <= '0;
            est_rd_en     <= 1'b0;
            est_rd_addr   <= '0;
            rd_data       <= '0;
            rd_data_valid <= 1'b0;
        end else begin
            est_wr_en     <= wr_en;
            est_wr_addr   <= wr_addr;
            est_wr_data   <= wr_data;
            est_rd_en     <= rd_en;
            est_rd_addr   <= rd_addr;
            rd_data       <= rd_data_next;
            rd_data_valid <= rd_data_valid_next;
        end
    end

endmodule

/* source/glb_cfg_top.sv */
// Global buffer configuration chain.
// Tiles linked west to east, each taking its position as tile id.

`timescale 1ns/1ps

module glb_cfg_top
    import glb_param_pkg::*, glb_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_en,
    input  cfg_addr_t wr_addr,
    input  cfg_data_t wr_data,
    input  logic      rd_en,
    input  cfg_addr_t rd_addr,
    output cfg_data_t rd_data,
    output logic      rd_data_valid
);

    // Index i is the west side of tile i, index NUM_TILES is past the east end.
    logic      chain_wr_en         [NUM_TILES+1];
    cfg_addr_t chain_wr_addr       [NUM_TILES+1];
    cfg_data_t chain_wr_data       [NUM_TILES+1];
    logic      chain_rd_en         [NUM_TILES+1];
    cfg_addr_t chain_rd_addr       [NUM_TILES+1];
    cfg_data_t chain_rd_data       [NUM_TILES+1];
    logic      chain_rd_data_valid [NUM_TILES+1];

    assign chain_wr_en[0]   = wr_en;
    assign chain_wr_addr[0] = wr_addr;
    assign chain_wr_data[0] = wr_data;
    assign chain_rd_en[0]   = rd_en;
    assign chain_rd_addr[0] = rd_addr;
    assign rd_data          = chain_rd_data[0];
    assign rd_data_valid    = chain_rd_data_valid[0];

    // nothing returns from beyond the last tile.
    assign chain_rd_data[NUM_TILES]       = '0;
    assign chain_rd_data_valid[NUM_TILES] = 1'b0;

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        glb_tile glb_tile_inst (
            .clk               (clk),
            .reset             (reset),
            .tile_id           (tile_id_t'(i)),
            .wr_en             (chain_wr_en[i]),
            .wr_addr           (chain_wr_addr[i]),
            .wr_data           (chain_wr_data[i]),
            .rd_en             (chain_rd_en[i]),
            .rd_addr           (chain_rd_addr[i]),
            .rd_data           (chain_rd_data[i]),
            .rd_data_valid     (chain_rd_data_valid[i]),
            .est_wr_en         (chain_wr_en[i+1]),
            .est_wr_addr       (chain_wr_addr[i+1]),
            .est_wr_data       (chain_wr_data[i+1]),
            .est_rd_en         (chain_rd_en[i+1]),
            .est_rd_addr       (chain_rd_addr[i+1]),
            .est_rd_data       (chain_rd_data[i+1]),
            .est_rd_data_valid (chain_rd_data_valid[i+1])
        );
    end

endmodule
